/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = clb_tile_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/fabric_cfg.svh */
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// routing and slice geometry
`define FAB_CHN_WIDTH    4
`define FAB_CLB_IWIDTH   4
`define FAB_CLB_OWIDTH   2

// frame address of this tile
`define FAB_ID_WIDTH     3
`define FAB_TILE_ID      5

// configuration word layout
`define FAB_CFG_SIZE     90
`define FAB_SB_CFG_LO    0
`define FAB_CBE_CFG_LO   32
`define FAB_CBN_CFG_LO   44
`define FAB_SLICE_CFG_LO 56
`define FAB_CB_CFG_SIZE  12

`endif

/* logic/clb_tile.sv */
`include "fabric_cfg.svh"

module clb_tile (
  input  logic              clk,
  input  logic              rst,
  input  logic              cfg_in_start,
  input  logic              cfg_bit_in,
  output logic              cfg_out_start,
  output logic              cfg_bit_out,
  input  fabric_pkg::chan_t north_in,
  output fabric_pkg::chan_t north_out,
  input  fabric_pkg::chan_t east_in,
  output fabric_pkg::chan_t east_out,
  input  fabric_pkg::chan_t south_in,
  output fabric_pkg::chan_t south_out,
  input  fabric_pkg::chan_t west_in,
  output fabric_pkg::chan_t west_out
);

  localparam int SB_CFG_W    = 8 * `FAB_CHN_WIDTH;
  localparam int SLICE_CFG_W = `FAB_CFG_SIZE - `FAB_SLICE_CFG_LO;

  fabric_pkg::cfg_word_t cfg;

  fabric_pkg::chan_t sb_south_in;
  fabric_pkg::chan_t sb_south_out;
  fabric_pkg::chan_t sb_west_in;
  fabric_pkg::chan_t sb_west_out;

  fabric_pkg::clbi_t cb_e_clb_in;
  fabric_pkg::clbi_t cb_n_clb_in;
  fabric_pkg::clbo_t slice_out;

  config_loader cfg_blk (
    .clk          (clk),
    .rst          (rst),
    .cfg_in_start (cfg_in_start),
    .cfg_bit_in   (cfg_bit_in),
    .cfg_out_start(cfg_out_start),
    .cfg_bit_out  (cfg_bit_out),
    .cfg          (cfg)
  );

  // north and east channels go straight to the switch box
  switch_box sb (
    .north_in (north_in),
    .east_in  (east_in),
    .south_in (sb_south_in),
    .west_in  (sb_west_in),
    .north_out(north_out),
    .east_out (east_out),
    .south_out(sb_south_out),
    .west_out (sb_west_out),
    .cfg      (cfg[`FAB_SB_CFG_LO +: SB_CFG_W])
  );

  conn_box cb_e (
    .sb_out  (sb_south_out),  // south side of sb
    .sb_in   (sb_south_in),
    .edge_in (south_in),
    .edge_out(south_out),
    .clb_out (slice_out),
    .clb_in  (cb_e_clb_in),
    .cfg     (cfg[`FAB_CBE_CFG_LO +: `FAB_CB_CFG_SIZE])
  );

  conn_box cb_n (
    .sb_out  (sb_west_out),   // west side of sb
    .sb_in   (sb_west_in),
    .edge_in (west_in),
    .edge_out(west_out),
    .clb_out (slice_out),
    .clb_in  (cb_n_clb_in),
    .cfg     (cfg[`FAB_CBN_CFG_LO +: `FAB_CB_CFG_SIZE])
  );

  logic_slice clb (
    .clk    (clk),
    .rst    (rst),
    .lut0_in(cb_e_clb_in),
    .lut1_in(cb_n_clb_in),
    .out    (slice_out),
    .cfg    (cfg[`FAB_SLICE_CFG_LO +: SLICE_CFG_W])
  );

endmodule

/* logic/config_loader.sv */
`include "fabric_cfg.svh"

module config_loader (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_in_start,
  input  logic                  cfg_bit_in,
  output logic                  cfg_out_start,
  output logic                  cfg_bit_out,
  output fabric_pkg::cfg_word_t cfg
);

  localparam int CNT_W = $clog2(`FAB_CFG_SIZE);

  fabric_pkg::loader_state_t state;
  logic [CNT_W-1:0]          cnt;
  fabric_pkg::tile_id_t      id_q;    // frame address, msb first
  fabric_pkg::cfg_word_t     shadow;

  logic id_shift;
  logic pl_shift;
  logic id_last;
  logic pl_last;
  logic id_match;

  assign id_shift = cfg_in_start || (state == fabric_pkg::st_id);
  assign pl_shift = !cfg_in_start && (state == fabric_pkg::st_payload);
  assign id_last  = (cnt == CNT_W'(`FAB_ID_WIDTH - 1));
  assign pl_last  = (cnt == CNT_W'(`FAB_CFG_SIZE - 1));
  assign id_match = (id_q == fabric_pkg::tile_id_t'(`FAB_TILE_ID));

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= fabric_pkg::st_idle;
      cnt           <= '0;
      cfg           <= '0;
      cfg_out_start <= 1'b0;
      cfg_bit_out   <= 1'b0;
    end else begin
      cfg_out_start <= cfg_in_start;  // chain repeats every frame
      cfg_bit_out   <= cfg_bit_in;
      if (cfg_in_start) begin
        // first address bit comes with the start pulse, restarts any frame
        state <= fabric_pkg::st_id;
        cnt   <= CNT_W'(1);
      end else begin
        case (state)
          fabric_pkg::st_id: begin
            if (id_last) begin
              state <= fabric_pkg::st_payload;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          fabric_pkg::st_payload: begin
            if (pl_last) begin
              state <= fabric_pkg::st_idle;
              cnt   <= '0;
              if (id_match) begin
                cfg <= {shadow[`FAB_CFG_SIZE-2:0], cfg_bit_in};  // commit with last bit
              end
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          default: begin
            cnt <= '0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (id_shift) begin
      id_q <= {id_q[`FAB_ID_WIDTH-2:0], cfg_bit_in};
    end
    if (pl_shift) begin
      shadow <= {shadow[`FAB_CFG_SIZE-2:0], cfg_bit_in};  // first bit ends at msb
    end
  end

endmodule

/* logic/conn_box.sv */
`include "fabric_cfg.svh"

module conn_box (
  input  fabric_pkg::chan_t   sb_out,
  output fabric_pkg::chan_t   sb_in,
  input  fabric_pkg::chan_t   edge_in,
  output fabric_pkg::chan_t   edge_out,
  input  fabric_pkg::clbo_t   clb_out,
  output fabric_pkg::clbi_t   clb_in,
  input  fabric_pkg::cb_cfg_t cfg
);

  localparam int SEL_W  = $clog2(`FAB_CHN_WIDTH);
  localparam int DRV_LO = SEL_W * `FAB_CLB_IWIDTH;  // drive enables after pin selects

  // pin selection from outbound switch box tracks
  for (genvar i = 0; i < `FAB_CLB_IWIDTH; i++) begin : g_pin
    logic [SEL_W-1:0] sel;

    assign sel       = cfg[SEL_W*i +: SEL_W];
    assign clb_in[i] = sb_out[sel];
  end

  // slice outputs override tracks where drive bit set
  for (genvar t = 0; t < `FAB_CHN_WIDTH; t++) begin : g_drive
    assign edge_out[t] = cfg[DRV_LO + t] ? clb_out[t % `FAB_CLB_OWIDTH] : sb_out[t];
  end

  assign sb_in = edge_in;  // inbound side untouched

endmodule

/* logic/fabric_pkg.sv */
`include "fabric_cfg.svh"

package fabric_pkg;

  typedef logic [`FAB_CHN_WIDTH-1:0]   chan_t;     // tracks of one channel
  typedef logic [`FAB_CLB_IWIDTH-1:0]  clbi_t;     // inputs of one lut
  typedef logic [`FAB_CLB_OWIDTH-1:0]  clbo_t;
  typedef logic [`FAB_ID_WIDTH-1:0]    tile_id_t;
  typedef logic [`FAB_CFG_SIZE-1:0]    cfg_word_t;
  typedef logic [`FAB_CB_CFG_SIZE-1:0] cb_cfg_t;

  typedef enum logic [1:0] {
    st_idle,
    st_id,
    st_payload
  } loader_state_t;

endpackage

/* logic/logic_slice.sv */
`include "fabric_cfg.svh"

module logic_slice (
  input  logic                                     clk,
  input  logic                                     rst,
  input  fabric_pkg::clbi_t                        lut0_in,
  input  fabric_pkg::clbi_t                        lut1_in,
  output fabric_pkg::clbo_t                        out,
  input  logic [`FAB_CFG_SIZE-`FAB_SLICE_CFG_LO-1:0] cfg
);

  localparam int LUT_SIZE = 2 ** `FAB_CLB_IWIDTH;
  localparam int REG_LO   = `FAB_CLB_OWIDTH * LUT_SIZE;  // register selects follow tables

  fabric_pkg::clbi_t lut_in [`FAB_CLB_OWIDTH];
  fabric_pkg::clbo_t lut_val;
  fabric_pkg::clbo_t lut_q;

  assign lut_in[0] = lut0_in;
  assign lut_in[1] = lut1_in;

  for (genvar j = 0; j < `FAB_CLB_OWIDTH; j++) begin : g_lut
    logic [LUT_SIZE-1:0] table_bits;

    assign table_bits = cfg[j*LUT_SIZE +: LUT_SIZE];
    assign lut_val[j] = table_bits[lut_in[j]];       // truth table lookup
    assign out[j]     = cfg[REG_LO + j] ? lut_q[j] : lut_val[j];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lut_q <= '0;
    end else begin
      lut_q <= lut_val;
    end
  end

endmodule

/* logic/switch_box.sv */
`include "fabric_cfg.svh"

module switch_box (
  input  fabric_pkg::chan_t             north_in,
  input  fabric_pkg::chan_t             east_in,
  input  fabric_pkg::chan_t             south_in,
  input  fabric_pkg::chan_t             west_in,
  output fabric_pkg::chan_t             north_out,
  output fabric_pkg::chan_t             east_out,
  output fabric_pkg::chan_t             south_out,
  output fabric_pkg::chan_t             west_out,
  input  logic [8*`FAB_CHN_WIDTH-1:0]   cfg
);

  // sides indexed 0 north, 1 east, 2 south, 3 west
  fabric_pkg::chan_t      side_in  [4];
  wire fabric_pkg::chan_t side_out [4];

  assign side_in[0] = north_in;
  assign side_in[1] = east_in;
  assign side_in[2] = south_in;
  assign side_in[3] = west_in;

  for (genvar d = 0; d < 4; d++) begin : g_side
    for (genvar t = 0; t < `FAB_CHN_WIDTH; t++) begin : g_track
      logic [3:0] cand;
      logic [1:0] sel;

      assign sel  = cfg[2*(`FAB_CHN_WIDTH*d + t) +: 2];
      // select k picks side (d+k) mod 4, zero select parks the track low
      assign cand = {side_in[(d+3)%4][t], side_in[(d+2)%4][t],
                     side_in[(d+1)%4][t], 1'b0};
      assign side_out[d][t] = cand[sel];
    end
  end

  assign north_out = side_out[0];
  assign east_out  = side_out[1];
  assign south_out = side_out[2];
  assign west_out  = side_out[3];

endmodule

/* sim.f */
+incdir+include
logic/fabric_pkg.sv
logic/config_loader.sv
logic/logic_slice.sv
logic/switch_box.sv
logic/conn_box.sv
logic/clb_tile.sv
tb/tb_clk_gen.sv
tb/tile_checker.sv
tb/clb_tile_tb.sv

/* tb/clb_tile_tb.sv */
`include "fabric_cfg.svh"

module clb_tile_tb;

  localparam string STIM_FILE = "tb/tile_input.txt";

  logic              clk;
  logic              rst;
  logic              cfg_in_start;
  logic              cfg_bit_in;
  logic              cfg_out_start;
  logic              cfg_bit_out;
  fabric_pkg::chan_t north_in;
  fabric_pkg::chan_t east_in;
  fabric_pkg::chan_t south_in;
  fabric_pkg::chan_t west_in;
  fabric_pkg::chan_t north_out;
  fabric_pkg::chan_t east_out;
  fabric_pkg::chan_t south_out;
  fabric_pkg::chan_t west_out;

  logic              chain_check;
  logic              chan_check;
  logic              test_done;
  logic              report;
  logic              frame_test;
  logic              exp_start;
  logic              exp_bit;
  logic              last_start;  // chain values of the previous cycle
  logic              last_bit;
  fabric_pkg::chan_t exp_north;
  fabric_pkg::chan_t exp_east;
  fabric_pkg::chan_t exp_south;
  fabric_pkg::chan_t exp_west;
  int                test_num;
  int                error_count;
  int                tb_errors;
  int                line_count;
  logic              load_done;

  tb_clk_gen #(.PERIOD(20)) clk_gen (.clk(clk));

  clb_tile clb_tile_inst (.*);

  tile_checker check_unit (.*);

  // one cycle with inputs changing 2 units after the rising edge
  task automatic step_cycle(input logic start, input logic bit_val);
    @(posedge clk);
    #2;
    exp_start    = last_start;
    exp_bit      = last_bit;
    cfg_in_start = start;
    cfg_bit_in   = bit_val;
    last_start   = start;
    last_bit     = bit_val;
    chan_check   = 1'b0;
    test_done    = 1'b0;
  endtask

  task automatic run_frame(input fabric_pkg::tile_id_t addr,
                           input fabric_pkg::cfg_word_t payload);
    for (int i = 0; i < `FAB_ID_WIDTH; i++) begin
      step_cycle(i == 0, addr[`FAB_ID_WIDTH-1-i]);  // address msb first
    end
    for (int i = `FAB_CFG_SIZE - 1; i >= 0; i--) begin
      step_cycle(1'b0, payload[i]);
    end
    step_cycle(1'b0, 1'b0);  // last bit shows on the chain output
    frame_test = 1'b1;
    test_done  = 1'b1;
  endtask

  task automatic run_vector(input logic [15:0] vin, input logic [15:0] vexp,
                            input logic edge_sep);
    step_cycle(1'b0, 1'b0);
    {north_in, east_in, south_in, west_in}     = vin;
    {exp_north, exp_east, exp_south, exp_west} = vexp;
    if (edge_sep) begin
      step_cycle(1'b0, 1'b0);
    end
    frame_test = 1'b0;
    chan_check = 1'b1;
    test_done  = 1'b1;
  endtask

  initial begin
    int          fd;
    string       line;
    string       rest;
    logic [7:0]  f_addr;
    logic [95:0] f_payload;
    logic [15:0] v_in;
    logic [15:0] v_exp;
    logic [3:0]  v_edge;

    rst          = 1'b1;
    cfg_in_start = 1'b0;
    cfg_bit_in   = 1'b0;
    north_in     = '0;
    east_in      = '0;
    south_in     = '0;
    west_in      = '0;
    chain_check  = 1'b0;
    chan_check   = 1'b0;
    test_done    = 1'b0;
    report       = 1'b0;
    frame_test   = 1'b0;
    exp_start    = 1'b0;
    exp_bit      = 1'b0;
    last_start   = 1'b0;
    last_bit     = 1'b0;
    test_num     = 0;
    tb_errors    = 0;
    line_count   = 0;
    load_done    = 1'b0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      $display("Testbench failed");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_count++;
      end
      $fclose(fd);
      load_done = 1'b1;
      fd = $fopen(STIM_FILE, "r");

      repeat (10) @(posedge clk);
      #2;
      rst         = 1'b0;
      chain_check = 1'b1;

      while ($fgets(line, fd) != 0) begin
        rest = line.substr(1, line.len() - 1);
        if (line[0] == "F" && $sscanf(rest, "%h %h", f_addr, f_payload) == 2) begin
          test_num++;
          run_frame(fabric_pkg::tile_id_t'(f_addr), fabric_pkg::cfg_word_t'(f_payload));
        end else if (line[0] == "V" &&
                     $sscanf(rest, "%h %h %h", v_in, v_exp, v_edge) == 3) begin
          test_num++;
          run_vector(v_in, v_exp, v_edge[0]);
        end else if (line[0] != "#" && line.len() > 1) begin
          $display("stimulus line not understood: %s", line);
          tb_errors++;
        end
      end
      $fclose(fd);

      step_cycle(1'b0, 1'b0);
      report = 1'b1;
      @(negedge clk);
      #1;
      if (error_count == 0 && tb_errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

  // watchdog bounded by a full frame per stimulus line
  initial begin
    longint limit;

    wait (load_done);
    limit = (longint'(line_count) * (`FAB_ID_WIDTH + `FAB_CFG_SIZE + 4) + 20) * 20;
    #(limit);
    $display("run timed out after %0d time units before the stimulus ended", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

endmodule

/* tb/tile_checker.sv */
`include "fabric_cfg.svh"

module tile_checker (
  input  logic              clk,
  input  logic              chain_check,
  input  logic              chan_check,
  input  logic              test_done,
  input  logic              report,
  input  int                test_num,
  input  logic              frame_test,
  input  logic              exp_start,
  input  logic              exp_bit,
  input  fabric_pkg::chan_t exp_north,
  input  fabric_pkg::chan_t exp_east,
  input  fabric_pkg::chan_t exp_south,
  input  fabric_pkg::chan_t exp_west,
  input  logic              cfg_out_start,
  input  logic              cfg_bit_out,
  input  fabric_pkg::chan_t north_out,
  input  fabric_pkg::chan_t east_out,
  input  fabric_pkg::chan_t south_out,
  input  fabric_pkg::chan_t west_out,
  output int                error_count
);

  int checks;
  int tests;
  int test_errors;

  task automatic compare_value(input string name, input fabric_pkg::chan_t got,
                               input fabric_pkg::chan_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  initial begin
    error_count = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (chain_check) begin
      compare_value("cfg_out_start", fabric_pkg::chan_t'(cfg_out_start),
                    fabric_pkg::chan_t'(exp_start));
      compare_value("cfg_bit_out", fabric_pkg::chan_t'(cfg_bit_out),
                    fabric_pkg::chan_t'(exp_bit));
    end
    if (chan_check) begin
      compare_value("north_out", north_out, exp_north);
      compare_value("east_out", east_out, exp_east);
      compare_value("south_out", south_out, exp_south);
      compare_value("west_out", west_out, exp_west);
    end
    if (test_done) begin
      tests++;
      $display("test %0d (%s): %s", test_num, frame_test ? "frame" : "vector",
               test_errors == 0 ? "ok" : "FAILED");
      test_errors = 0;
    end
    if (report) begin
      $display("%0d tests, %0d checks, %0d errors", tests, checks, error_count);
    end
  end

endmodule

/* tb/tile_input.txt */
# F <tile address> <90-bit configuration word, msb first>
# V <inputs north east south west> <expected outputs north east south west> <1: edge before check>
V FFFF 0000 0
F 5 0000000000000004E93E439
V F000 0888 0
V 0F00 1011 0
V 00F0 2202 0
V 000F 4440 0
V A53C 7EDB 0
V 5AC3 0000 1
# frame for another tile, routing stays
F 2 3FFFFFFFFFFFFFFFFFFFFFF
V A53C 7EDB 0
# and4 on south track 0, parity on west track 3
F 5 0699680008E41E455AA0000
V F359 00F7 0
V 7359 006F 0
V E000 00EE 0
V 1000 0009 0
V 0000 0000 0
# same with both slice outputs registered
F 5 3699680008E41E455AA0000
V F000 00F7 1
V 7000 0077 0
V 0000 0008 0
V E000 00EE 1
V F000 00F7 1
